/* common/mul_pkg.sv */
package mul_pkg;

	// RV64M multiply operations, funct3 order is not kept.
	typedef enum logic [2:0] {
		op_mul    = 3'd0,
		op_mulh   = 3'd1,
		op_mulhsu = 3'd2,
		op_mulhu  = 3'd3,
		op_mulw   = 3'd4
	} mul_op_e;

	localparam int xlen = 64;

	// two extra bits so every signedness mix fits a signed booth input.
	localparam int ext_width = xlen + 2;

	localparam int pp_count = ext_width / 2; // one booth row per bit pair.

	localparam int prod_width = 2 * ext_width;

endpackage

/* common/arb_pkg.sv */
package arb_pkg;

	localparam int num_ports = 2; // one per issue pipe.

	localparam int port_id_w = $clog2(num_ports);

endpackage

/* rtl/mul_arbiter.sv */
module mul_arbiter
	import mul_pkg::*;
	import arb_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req0_valid,
	input  logic                 req1_valid,
	input  mul_op_e              req0_op,
	input  mul_op_e              req1_op,
	input  logic [xlen-1:0]      req0_a,
	input  logic [xlen-1:0]      req0_b,
	input  logic [xlen-1:0]      req1_a,
	input  logic [xlen-1:0]      req1_b,
	output logic                 req0_ready,
	output logic                 req1_ready,
	output logic                 issue_valid,
	output mul_op_e              issue_op,
	output logic [xlen-1:0]      issue_a,
	output logic [xlen-1:0]      issue_b,
	output logic [port_id_w-1:0] issue_id,
	input  logic                 issue_ready
);

	logic [num_ports-1:0] grant;
	logic [port_id_w-1:0] last_id;
	logic                 live; // first cycle out of reset opens the ports.

	// on a tie the port not served last wins.
	assign grant[0] = live & req0_valid & (~req1_valid | (last_id == 1'b1));
	assign grant[1] = live & req1_valid & (~req0_valid | (last_id == 1'b0));

	assign req0_ready  = grant[0] & issue_ready;
	assign req1_ready  = grant[1] & issue_ready;
	assign issue_valid = |grant;
	assign issue_id    = grant[1];
	assign issue_op    = grant[1] ? req1_op : req0_op;
	assign issue_a     = grant[1] ? req1_a : req0_a;
	assign issue_b     = grant[1] ? req1_b : req0_b;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			live    <= 1'b0;
			last_id <= '1; // port 0 goes first.
		end else begin
			live <= 1'b1;
			if (issue_valid && issue_ready)
				last_id <= issue_id;
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({req1_ready, req0_ready}));

	// a stalled grant stays with the same port until the core takes it.
	a_grant_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid && !issue_ready |=> issue_valid && $stable(issue_id));

endmodule

/* multiplier/booth_pp_gen.sv */
module booth_pp_gen
	import mul_pkg::*;
(
	input  mul_op_e               op,
	input  logic [xlen-1:0]       a,
	input  logic [xlen-1:0]       b,
	output logic [prod_width-1:0] pp [pp_count],
	output logic [pp_count-1:0]   neg
);

	logic                  a_signed;
	logic                  b_signed;
	logic [ext_width-1:0]  a_ext;
	logic [ext_width-1:0]  b_ext;
	logic [ext_width:0]    a_pad;
	logic [prod_width-1:0] b_wide;

	// mul only keeps the low half, so its signedness is free.
	assign a_signed = (op == op_mul) || (op == op_mulh) || (op == op_mulhsu);
	assign b_signed = (op == op_mul) || (op == op_mulh);

	always_comb begin
		if (op == op_mulw) begin
			a_ext = {{(ext_width-32){a[31]}}, a[31:0]};
			b_ext = {{(ext_width-32){b[31]}}, b[31:0]};
		end else begin
			a_ext = {{(ext_width-xlen){a_signed & a[xlen-1]}}, a};
			b_ext = {{(ext_width-xlen){b_signed & b[xlen-1]}}, b};
		end
	end

	assign a_pad  = {a_ext, 1'b0}; // implicit bit below the lsb.
	assign b_wide = {{(prod_width-ext_width){b_ext[ext_width-1]}}, b_ext};

	for (genvar i = 0; i < pp_count; i++) begin : g_row
		logic [2:0]            grp;
		logic                  one;
		logic                  two;
		logic [prod_width-1:0] mag;

		assign grp = a_pad[2*i+2 -: 3];
		assign one = grp[1] ^ grp[0];
		assign two = (grp == 3'b011) || (grp == 3'b100);
		// 111 is zero, not minus zero.
		assign neg[i] = grp[2] & ~(grp[1] & grp[0]);
		assign mag = one ? b_wide : (two ? b_wide << 1 : '0);

		// ones complement here, the +1 rides in neg at column 2i.
		assign pp[i] = (neg[i] ? ~mag : mag) << (2 * i);
	end

endmodule

/* multiplier/wallace_reduce.sv */
module wallace_reduce
	import mul_pkg::*;
(
	input  logic [prod_width-1:0] pp [pp_count],
	input  logic [pp_count-1:0]   neg,
	output logic [prod_width-1:0] sum,
	output logic [prod_width-1:0] carry
);

	function automatic int rows_at(int lvl);
		int n;
		n = pp_count + 1;
		for (int i = 0; i < lvl; i++)
			n = 2 * (n / 3) + n % 3;
		return n;
	endfunction

	function automatic int count_levels(int n);
		int lvl;
		lvl = 0;
		while (n > 2) begin
			n = 2 * (n / 3) + n % 3;
			lvl++;
		end
		return lvl;
	endfunction

	localparam int num_levels = count_levels(pp_count + 1);

	logic [prod_width-1:0] neg_row;

	for (genvar i = 0; i < pp_count; i++) begin : g_neg
		assign neg_row[2*i+1 -: 2] = {1'b0, neg[i]};
	end
	assign neg_row[prod_width-1:2*pp_count] = '0;

	for (genvar l = 0; l < num_levels; l++) begin : g_lvl
		localparam int n_in  = rows_at(l);
		localparam int n_out = rows_at(l + 1);
		localparam int n_fa  = n_in / 3;

		logic [prod_width-1:0] row_in  [n_in];
		logic [prod_width-1:0] row_out [n_out];

		if (l == 0) begin : g_first
			for (genvar r = 0; r < pp_count; r++) begin : g_pp
				assign row_in[r] = pp[r];
			end
			assign row_in[pp_count] = neg_row;
		end else begin : g_next
			for (genvar r = 0; r < n_in; r++) begin : g_row
				assign row_in[r] = g_lvl[l-1].row_out[r];
			end
		end

		for (genvar g = 0; g < n_fa; g++) begin : g_csa
			assign row_out[2*g+1][0] = 1'b0;
			for (genvar c = 0; c < prod_width; c++) begin : g_col
				logic x;
				logic y;
				logic z;

				assign x = row_in[3*g][c];
				assign y = row_in[3*g+1][c];
				assign z = row_in[3*g+2][c];
				assign row_out[2*g][c] = x ^ y ^ z;
				if (c < prod_width - 1) begin : g_cy
					assign row_out[2*g+1][c+1] = (x & y) | (x & z) | (y & z);
				end
			end
		end

		// leftover rows skip this layer.
		for (genvar r = 0; r < n_in % 3; r++) begin : g_pass
			assign row_out[2*n_fa+r] = row_in[3*n_fa+r];
		end
	end

	assign sum   = g_lvl[num_levels-1].row_out[0];
	assign carry = g_lvl[num_levels-1].row_out[1];

endmodule

/* multiplier/mul_core.sv */
module mul_core
	import mul_pkg::*;
	import arb_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 issue_valid,
	input  mul_op_e              issue_op,
	input  logic [xlen-1:0]      issue_a,
	input  logic [xlen-1:0]      issue_b,
	input  logic [port_id_w-1:0] issue_id,
	output logic                 issue_ready,
	output logic                 out_valid,
	output logic [port_id_w-1:0] out_id,
	output logic [xlen-1:0]      out_data,
	input  logic                 out_ready
);

	logic [prod_width-1:0] pp [pp_count];
	logic [pp_count-1:0]   neg;
	logic [prod_width-1:0] csa_sum;
	logic [prod_width-1:0] csa_carry;
	logic                  advance;

	logic                  s1_valid;
	logic [2*xlen-1:0]     s1_sum;
	logic [2*xlen-1:0]     s1_carry;
	mul_op_e               s1_op;
	logic [port_id_w-1:0]  s1_id;

	logic [2*xlen-1:0]     prod;
	logic [xlen-1:0]       result;

	logic                  s2_valid;
	logic [xlen-1:0]       s2_data;
	logic [port_id_w-1:0]  s2_id;

	booth_pp_gen booth_pp_gen_i (
		.op  (issue_op),
		.a   (issue_a),
		.b   (issue_b),
		.pp  (pp),
		.neg (neg)
	);

	wallace_reduce wallace_reduce_i (
		.pp    (pp),
		.neg   (neg),
		.sum   (csa_sum),
		.carry (csa_carry)
	);

	// whole pipe moves together, only a blocked result holds it.
	assign advance     = !(s2_valid && !out_ready);
	assign issue_ready = advance;

	assign prod = s1_sum + s1_carry;

	always_comb begin
		case (s1_op)
			op_mul:  result = prod[xlen-1:0];
			op_mulw: result = {{(xlen/2){prod[xlen/2-1]}}, prod[xlen/2-1:0]};
			default: result = prod[2*xlen-1:xlen];
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= issue_valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			s1_sum   <= csa_sum[2*xlen-1:0]; // columns above 127 hold sign fill only.
			s1_carry <= csa_carry[2*xlen-1:0];
			s1_op    <= issue_op;
			s1_id    <= issue_id;
			s2_data  <= result;
			s2_id    <= s1_id;
		end
	end

	assign out_valid = s2_valid;
	assign out_id    = s2_id;
	assign out_data  = s2_data;

	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_id));

endmodule

/* rtl/mul_unit.sv */
module mul_unit
	import mul_pkg::*;
	import arb_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            req0_valid,
	input  mul_op_e         req0_op,
	input  logic [xlen-1:0] req0_a,
	input  logic [xlen-1:0] req0_b,
	output logic            req0_ready,
	input  logic            req1_valid,
	input  mul_op_e         req1_op,
	input  logic [xlen-1:0] req1_a,
	input  logic [xlen-1:0] req1_b,
	output logic            req1_ready,
	output logic            resp0_valid,
	output logic [xlen-1:0] resp0_data,
	input  logic            resp0_ready,
	output logic            resp1_valid,
	output logic [xlen-1:0] resp1_data,
	input  logic            resp1_ready
);

	logic                 issue_valid;
	mul_op_e              issue_op;
	logic [xlen-1:0]      issue_a;
	logic [xlen-1:0]      issue_b;
	logic [port_id_w-1:0] issue_id;
	logic                 issue_ready;
	logic                 out_valid;
	logic [port_id_w-1:0] out_id;
	logic [xlen-1:0]      out_data;
	logic                 out_ready;

	mul_arbiter mul_arbiter_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req0_valid  (req0_valid),
		.req1_valid  (req1_valid),
		.req0_op     (req0_op),
		.req1_op     (req1_op),
		.req0_a      (req0_a),
		.req0_b      (req0_b),
		.req1_a      (req1_a),
		.req1_b      (req1_b),
		.req0_ready  (req0_ready),
		.req1_ready  (req1_ready),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_id    (issue_id),
		.issue_ready (issue_ready)
	);

	mul_core mul_core_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_id    (issue_id),
		.issue_ready (issue_ready),
		.out_valid   (out_valid),
		.out_id      (out_id),
		.out_data    (out_data),
		.out_ready   (out_ready)
	);

	// results leave in issue order, out_id picks the port.
	assign resp0_valid = out_valid && (out_id == 1'b0);
	assign resp1_valid = out_valid && (out_id == 1'b1);
	assign resp0_data  = out_data;
	assign resp1_data  = out_data;
	assign out_ready   = out_id ? resp1_ready : resp0_ready;

endmodule

/* tests/mul_checker.sv */
module mul_checker
	import mul_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            req0_valid,
	input  logic            req0_ready,
	input  logic            req1_valid,
	input  logic            req1_ready,
	input  logic            resp0_valid,
	input  logic [xlen-1:0] resp0_data,
	input  logic            resp0_ready,
	input  logic            resp1_valid,
	input  logic [xlen-1:0] resp1_data,
	input  logic            resp1_ready,
	output int              tests_done,
	output int              errors
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [63:0]     vec [320];
	int              exp0[$];
	int              exp1[$];
	int              ptr0 = 0;
	int              ptr1 = 0;
	int              when0[$]; // accept edge of each request in flight.
	int              when1[$];
	int              stalls0[$];
	int              stalls1[$];
	int              cyc = 0;
	int              stall_cnt = 0;
	int              since_reset = 0;
	int              last_port = -1;
	int              n_tests = 0;
	int              n_err = 0;
	logic            held0 = 1'b0;
	logic            held1 = 1'b0;
	logic [xlen-1:0] last0 = '0;
	logic [xlen-1:0] last1 = '0;

	assign tests_done = n_tests;
	assign errors     = n_err;

	initial begin
		$readmemh("tests/mul_stimulus.txt", vec);
		for (int i = 0; i < 64; i++) begin
			if (vec[5*i] == 64'hff)
				break;
			if (vec[5*i] == 64'd0)
				exp0.push_back(i);
			else
				exp1.push_back(i);
		end
	end

	task automatic report_error(input string msg);
		$display("error at %0d ns: %s", $time, msg);
		n_err++;
	endtask

	task automatic take_response(input int port, input logic [xlen-1:0] data);
		int      idx;
		int      t_acc;
		int      s_acc;
		mul_op_e op;
		if ((port == 0 && when0.size() == 0) || (port == 1 && when1.size() == 0)) begin
			report_error($sformatf("port %0d gave a response with no request open", port));
		end else begin
			if (port == 0) begin
				idx   = exp0[ptr0];
				ptr0++;
				t_acc = when0.pop_front();
				s_acc = stalls0.pop_front();
			end else begin
				idx   = exp1[ptr1];
				ptr1++;
				t_acc = when1.pop_front();
				s_acc = stalls1.pop_front();
			end
			op = mul_op_e'(vec[5*idx+1][2:0]);
			n_tests++;
			if (data !== vec[5*idx+4]) begin
				$display("Fail at %0d ns: port %0d test %0d %s expected %h got %h",
					$time, port, idx, op.name(), vec[5*idx+4], data);
				n_err++;
			end else begin
				$display("test %0d port %0d %s ok", idx, port, op.name());
			end
			// latency is only fixed when nothing stalled in between.
			if (s_acc == stall_cnt && cyc - t_acc != 2)
				report_error($sformatf("test %0d took %0d cycles instead of 2", idx, cyc - t_acc));
		end
	endtask

	always @(posedge clk) begin
		cyc++;
		if ((resp0_valid && !resp0_ready) || (resp1_valid && !resp1_ready))
			stall_cnt++;
		if (!rst_n) begin
			since_reset = 0;
			if (resp0_valid || resp1_valid)
				report_error("a response was valid during reset");
			if (req0_ready || req1_ready)
				report_error("a request was accepted during reset");
		end else begin
			since_reset++;
			if (since_reset <= 2 && (resp0_valid || resp1_valid))
				report_error("a response was valid right after reset");
			if (held0 && (!resp0_valid || resp0_data !== last0))
				report_error("port 0 response changed while stalled");
			if (held1 && (!resp1_valid || resp1_data !== last1))
				report_error("port 1 response changed while stalled");
			if (req0_valid && req1_valid && last_port >= 0 &&
					((req0_ready && last_port == 0) || (req1_ready && last_port == 1)))
				report_error("a tie went to the port served last");
			if (req0_valid && req0_ready) begin
				when0.push_back(cyc);
				stalls0.push_back(stall_cnt);
				last_port = 0;
			end
			if (req1_valid && req1_ready) begin
				when1.push_back(cyc);
				stalls1.push_back(stall_cnt);
				last_port = 1;
			end
			if (resp0_valid && resp0_ready)
				take_response(0, resp0_data);
			if (resp1_valid && resp1_ready)
				take_response(1, resp1_data);
		end
		held0 = resp0_valid && !resp0_ready;
		held1 = resp1_valid && !resp1_ready;
		last0 = resp0_data;
		last1 = resp1_data;
	end

endmodule

/* tests/tb_mul_unit.sv */
module tb_mul_unit
	import mul_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic [63:0]     vec [320]; // five words per vector.
	int              list0[$];
	int              list1[$];
	int              n_vec;
	int              head0 = 0;
	int              head1 = 0;
	int              accepted = 0;
	int              cycles = 0;
	int              limit;
	int              tests_done;
	int              errors;
	logic            timed_out;
	logic [31:0]     seed = 32'h3f0a_61ec;
	logic            bp_on = 1'b0;
	logic            acc0 = 1'b0;
	logic            acc1 = 1'b0;

	logic            clk = 1'b0;
	logic            rst_n = 1'b0;
	logic            req0_valid = 1'b0;
	mul_op_e         req0_op = op_mul;
	logic [xlen-1:0] req0_a = '0;
	logic [xlen-1:0] req0_b = '0;
	logic            req0_ready;
	logic            req1_valid = 1'b0;
	mul_op_e         req1_op = op_mul;
	logic [xlen-1:0] req1_a = '0;
	logic [xlen-1:0] req1_b = '0;
	logic            req1_ready;
	logic            resp0_valid;
	logic [xlen-1:0] resp0_data;
	logic            resp0_ready = 1'b1;
	logic            resp1_valid;
	logic [xlen-1:0] resp1_data;
	logic            resp1_ready = 1'b1;

	mul_unit mul_unit_i (.*);

	mul_checker mul_checker_i (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic present_next(input int port);
		int idx;
		if (port == 0) begin
			idx        = list0[head0];
			req0_valid = 1'b1;
			req0_op    = mul_op_e'(vec[5*idx+1][2:0]);
			req0_a     = vec[5*idx+2];
			req0_b     = vec[5*idx+3];
		end else begin
			idx        = list1[head1];
			req1_valid = 1'b1;
			req1_op    = mul_op_e'(vec[5*idx+1][2:0]);
			req1_a     = vec[5*idx+2];
			req1_b     = vec[5*idx+3];
		end
	endtask

	always #2 clk = ~clk;

	always @(posedge clk) begin
		acc0   <= req0_valid && req0_ready;
		acc1   <= req1_valid && req1_ready;
		cycles <= cycles + 1;
	end

	// first half runs with both ports busy and no back-pressure.
	always @(negedge clk) begin
		seed  = lcg_next(seed);
		bp_on = accepted >= n_vec / 2;
		if (acc0) begin
			head0++;
			accepted++;
			req0_valid = 1'b0;
		end
		if (acc1) begin
			head1++;
			accepted++;
			req1_valid = 1'b0;
		end
		if (!req0_valid && head0 < list0.size() && (!bp_on || seed[25:24] != 2'b00))
			present_next(0);
		if (!req1_valid && head1 < list1.size() && (!bp_on || seed[27:26] != 2'b00))
			present_next(1);
		resp0_ready = !bp_on || seed[17:16] != 2'b00;
		resp1_ready = !bp_on || seed[19:18] != 2'b00;
	end

	initial begin
		$readmemh("tests/mul_stimulus.txt", vec);
		n_vec = 0;
		while (n_vec < 64 && vec[5*n_vec] != 64'hff) begin
			if (vec[5*n_vec] == 64'd0)
				list0.push_back(n_vec);
			else
				list1.push_back(n_vec);
			n_vec++;
		end
		limit = 8 * n_vec + 200;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		while (tests_done < n_vec && cycles < limit)
			@(posedge clk);
		timed_out = tests_done < n_vec;
		repeat (4) @(posedge clk); // room for a stray extra response.
		if (timed_out)
			$display("timeout: %0d of %0d responses seen after %0d cycles",
				tests_done, n_vec, cycles);
		$display("%0d tests, %0d errors", tests_done, errors);
		if (!timed_out && errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* tests/mul_stimulus.txt */
// port op a b expected, all hex; op 0 mul, 1 mulh, 2 mulhsu, 3 mulhu, 4 mulw.
// a line with port ff ends the list.
0 0 0000000000000003 0000000000000005 000000000000000f
1 0 0000000000000007 fffffffffffffffe fffffffffffffff2
0 0 0000000000000000 ffffffffffffffff 0000000000000000
1 1 0000000000000007 fffffffffffffffe ffffffffffffffff
0 0 0000000000000001 123456789abcdef0 123456789abcdef0
1 3 0000000000000007 fffffffffffffffe 0000000000000006
0 0 ffffffffffffffff ffffffffffffffff 0000000000000001
1 2 0000000000000002 ffffffffffffffff 0000000000000001
0 1 ffffffffffffffff ffffffffffffffff 0000000000000000
1 0 7fffffffffffffff 7fffffffffffffff 0000000000000001
0 3 ffffffffffffffff ffffffffffffffff fffffffffffffffe
1 1 7fffffffffffffff 7fffffffffffffff 3fffffffffffffff
0 2 ffffffffffffffff ffffffffffffffff ffffffffffffffff
1 3 7fffffffffffffff 7fffffffffffffff 3fffffffffffffff
0 1 8000000000000000 8000000000000000 4000000000000000
1 1 7fffffffffffffff 8000000000000000 c000000000000000
0 3 8000000000000000 8000000000000000 4000000000000000
1 4 0000000000010000 0000000000010000 0000000000000000
0 2 8000000000000000 8000000000000000 c000000000000000
1 4 ffffffffffffffff ffffffff80000000 ffffffff80000000
0 0 8000000000000000 ffffffffffffffff 8000000000000000
1 0 123456789abcdef0 0000000000000010 23456789abcdef00
0 1 8000000000000000 ffffffffffffffff 0000000000000000
1 3 123456789abcdef0 0000000000000010 0000000000000001
0 4 ffffffff00000003 1234567800000005 000000000000000f
1 1 0000000000000000 8000000000000000 0000000000000000
0 4 deadbeef7fffffff 0000000100000002 fffffffffffffffe
1 2 ffffffffffffffff 0000000000000002 ffffffffffffffff
0 4 0000000180000000 abcdef0000000001 ffffffff80000000
1 0 0000000100000000 0000000100000000 0000000000000000
0 3 0000000100000000 0000000100000000 0000000000000001
1 4 000000000000ffff 000000000000ffff fffffffffffe0001
0 1 0000000000000001 ffffffffffffffff ffffffffffffffff
1 2 8000000000000000 0000000000000001 ffffffffffffffff
ff 0 0 0 0

/* project.f */
common/mul_pkg.sv
common/arb_pkg.sv
rtl/mul_arbiter.sv
multiplier/booth_pp_gen.sv
multiplier/wallace_reduce.sv
multiplier/mul_core.sv
rtl/mul_unit.sv
tests/mul_checker.sv
tests/tb_mul_unit.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing --timescale 1ns/100ps --assert
TOP      = tb_mul_unit
RTL_TOP  = mul_unit
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) --binary -j 0 $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
